// File: logic/cache_pkg.sv
// cache directory package
// shared vector types, register map and default geometry

package cache_pkg;

	// ---------------------------------------------------------
	// widths
	// ---------------------------------------------------------
	localparam int ADDR_W     = 16;	// block address, no byte offset
	localparam int COUNT_W    = 16;	// statistics counters wrap
	localparam int REG_ADDR_W = 2;
	localparam int REG_DATA_W = 16;

	// ---------------------------------------------------------
	// vector types
	// ---------------------------------------------------------
	typedef logic [ADDR_W-1:0]     addr_t;	// tag in upper bits, set in lower bits
	typedef logic [COUNT_W-1:0]    count_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [REG_DATA_W-1:0] reg_data_t;

	// ---------------------------------------------------------
	// register map
	// ---------------------------------------------------------
	localparam reg_addr_t REG_CTRL     = 2'd0;	// write bit 0 to flush
	localparam reg_addr_t REG_HITS     = 2'd1;
	localparam reg_addr_t REG_MISSES   = 2'd2;
	localparam reg_addr_t REG_GEOMETRY = 2'd3;	// sets in high byte, ways in low byte

	// default geometry, overridden from the top level
	localparam int DEF_LINES = 16;
	localparam int DEF_WAYS  = 4;	// so 4 sets by default

endpackage

// File: logic/replace_if.sv
`timescale 1ns/10ps
// replacement handshake
// miss request from the tag directory, victim line back from the fifo controller

interface replace_if #(
	parameter int N_LINES = cache_pkg::DEF_LINES,
	parameter int N_WAYS  = cache_pkg::DEF_WAYS
);
	localparam int N_SETS = N_LINES / N_WAYS;
	localparam int SET_W  = (N_SETS > 1) ? $clog2(N_SETS) : 1;	// one bit even with one set
	localparam int LINE_W = $clog2(N_LINES);

	logic              miss;		// one cycle, directory wants a victim
	logic [SET_W-1:0]  miss_set;	// set of the missing block
	logic              flush;		// one cycle, zero all pointers
	logic              done;		// one cycle, victim_line is valid
	logic [LINE_W-1:0] victim_line;	// way above set

	// tag directory side
	modport requester (
		output miss, miss_set, flush,
		input  done, victim_line
	);

	// replacement controller side
	modport controller (
		input  miss, miss_set, flush,
		output done, victim_line
	);

endinterface

// File: logic/fifo_replacement.sv
`timescale 1ns/10ps
// fifo replacement controller
// round-robin way pointer per set, hands back {way, set} one cycle after a miss

module fifo_replacement #(
	parameter int N_LINES = cache_pkg::DEF_LINES,
	parameter int N_WAYS  = cache_pkg::DEF_WAYS
)(
	input  logic          clock_i,
	input  logic          resetn_i,
	replace_if.controller rpl
);

	// ---------------------------------------------------------
	// geometry
	// ---------------------------------------------------------
	localparam int N_SETS = N_LINES / N_WAYS;
	localparam int WAY_W  = $clog2(N_WAYS);
	localparam int LINE_W = $clog2(N_LINES);

	logic [WAY_W-1:0]  ptr_q [N_SETS];	// next victim way of each set
	logic [WAY_W-1:0]  cur_way;			// pointer of the requested set
	logic [WAY_W-1:0]  nxt_way;
	logic [LINE_W-1:0] victim_next;
	logic              done_q;
	logic [LINE_W-1:0] line_q;

	assign cur_way = ptr_q[rpl.miss_set];	// index is always 0 with one set
	assign nxt_way = (cur_way == WAY_W'(N_WAYS - 1)) ? '0 : cur_way + 1'b1;

	// line index is way above set, set field vanishes with a single set
	generate
		if (N_SETS > 1) begin : g_multi_set
			assign victim_next = {cur_way, rpl.miss_set};
		end else begin : g_single_set
			assign victim_next = cur_way;
		end
	endgenerate

	// ---------------------------------------------------------
	// pointer update
	// ---------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int s = 0; s < N_SETS; s++) begin
				ptr_q[s] <= '0;
			end
			done_q <= 1'b0;
		end else begin
			done_q <= rpl.miss;	// answer exactly one cycle later
			if (rpl.flush) begin
				for (int s = 0; s < N_SETS; s++) begin
					ptr_q[s] <= '0;
				end
			end else if (rpl.miss) begin
				ptr_q[rpl.miss_set] <= nxt_way;	// advance, wraps after last way
			end
		end
	end

	// victim line held until the next miss
	always_ff @(posedge clock_i) begin
		if (rpl.miss) begin
			line_q <= victim_next;
		end
	end

	assign rpl.done        = done_q;
	assign rpl.victim_line = line_q;

	// one miss in flight, answered on the next edge
	a_done_follows_miss: assert property (@(posedge clock_i) disable iff (!resetn_i)
		rpl.miss |=> rpl.done && !rpl.miss);

endmodule

// File: logic/tag_directory.sv
`timescale 1ns/10ps
// tag directory
// tag and valid arrays with a parallel compare over all ways of a set,
// misses go through the replacement controller before the tag is installed

module tag_directory #(
	parameter int N_LINES = cache_pkg::DEF_LINES,
	parameter int N_WAYS  = cache_pkg::DEF_WAYS
)(
	input  logic                       clock_i,
	input  logic                       resetn_i,
	input  logic                       lookup_i,		// one-cycle strobe
	input  cache_pkg::addr_t           lookup_addr_i,
	output logic                       resp_valid_o,
	output logic                       resp_hit_o,
	output logic [$clog2(N_LINES)-1:0] resp_line_o,
	output logic                       busy_o,
	input  logic                       flush_i,
	output logic                       hit_evt_o,
	output logic                       miss_evt_o,
	replace_if.requester               rpl
);

	// ---------------------------------------------------------
	// geometry
	// ---------------------------------------------------------
	localparam int N_SETS   = N_LINES / N_WAYS;
	localparam int SET_BITS = $clog2(N_SETS);				// 0 with one set
	localparam int SET_W    = (N_SETS > 1) ? SET_BITS : 1;
	localparam int LINE_W   = $clog2(N_LINES);
	localparam int TAG_W    = cache_pkg::ADDR_W - SET_BITS;

	typedef logic [TAG_W-1:0]  tag_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef enum logic [1:0] {S_IDLE, S_WAIT, S_INSTALL} state_t;

	state_t             state_q;
	tag_t               tag_mem [N_LINES];	// indexed by line, way above set
	logic [N_LINES-1:0] valid_q;
	tag_t               lk_tag;
	tag_t               miss_tag_q;			// tag waiting for its victim line
	logic [SET_W-1:0]   lk_set;
	logic               accept;
	logic               lk_hit;
	line_t              hit_line;

	assign lk_tag = lookup_addr_i[cache_pkg::ADDR_W-1 -: TAG_W];
	assign lk_set = SET_W'(lookup_addr_i % N_SETS);	// low bits, zero with one set
	assign accept = lookup_i && !busy_o;				// busy drops strobes silently

	assign rpl.flush = flush_i;	// pointers flush together with valid bits

	// ---------------------------------------------------------
	// compare across all ways of the set
	// ---------------------------------------------------------
	always_comb begin
		line_t way_line;
		lk_hit   = 1'b0;
		hit_line = '0;
		for (int w = 0; w < N_WAYS; w++) begin
			way_line = line_t'(w * N_SETS) + line_t'(lk_set);
			if (!lk_hit && valid_q[way_line] && tag_mem[way_line] == lk_tag) begin
				lk_hit   = 1'b1;	// first matching way wins
				hit_line = way_line;
			end
		end
	end

	// ---------------------------------------------------------
	// miss sequencing
	// ---------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q      <= S_IDLE;
			valid_q      <= '0;
			busy_o       <= 1'b0;
			resp_valid_o <= 1'b0;
			rpl.miss     <= 1'b0;
			hit_evt_o    <= 1'b0;
			miss_evt_o   <= 1'b0;
		end else begin
			// strobes low unless raised below
			resp_valid_o <= 1'b0;
			rpl.miss     <= 1'b0;
			hit_evt_o    <= 1'b0;
			miss_evt_o   <= 1'b0;
			if (resp_valid_o) begin
				busy_o <= 1'b0;	// free again the cycle after the response
			end
			if (flush_i) begin
				valid_q <= '0;
			end
			case (state_q)
				S_IDLE: begin
					if (accept) begin
						busy_o <= 1'b1;
						if (lk_hit) begin
							resp_valid_o <= 1'b1;	// hit answers at N+1
							hit_evt_o    <= 1'b1;
						end else begin
							rpl.miss   <= 1'b1;
							miss_evt_o <= 1'b1;
							state_q    <= S_WAIT;
						end
					end
				end
				S_WAIT: begin
					if (rpl.done) begin
						valid_q[rpl.victim_line] <= 1'b1;
						resp_valid_o             <= 1'b1;	// miss answers at N+3
						state_q                  <= S_INSTALL;
					end
				end
				S_INSTALL: state_q <= S_IDLE;	// response cycle
				default:   state_q <= S_IDLE;
			endcase
		end
	end

	// tag array and response payload
	always_ff @(posedge clock_i) begin
		if (accept) begin
			resp_hit_o   <= lk_hit;
			resp_line_o  <= hit_line;
			rpl.miss_set <= lk_set;
			miss_tag_q   <= lk_tag;
		end
		if (state_q == S_WAIT && rpl.done) begin
			tag_mem[rpl.victim_line] <= miss_tag_q;	// evicted tag simply overwritten
			resp_hit_o               <= 1'b0;
			resp_line_o              <= rpl.victim_line;
		end
	end

	// controller may only answer a pending miss
	a_done_in_wait: assert property (@(posedge clock_i) disable iff (!resetn_i)
		rpl.done |-> state_q == S_WAIT);

endmodule

// File: logic/cache_ctrl_regs.sv
`timescale 1ns/10ps
// cache control registers
// hit and miss counters, flush command and registered readback

module cache_ctrl_regs #(
	parameter int N_LINES = cache_pkg::DEF_LINES,
	parameter int N_WAYS  = cache_pkg::DEF_WAYS
)(
	input  logic                 clock_i,
	input  logic                 resetn_i,
	input  logic                 reg_wr_i,
	input  logic                 reg_rd_i,
	input  cache_pkg::reg_addr_t reg_addr_i,
	input  cache_pkg::reg_data_t reg_wdata_i,
	output logic                 reg_rvalid_o,
	output cache_pkg::reg_data_t reg_rdata_o,
	input  logic                 hit_evt_i,
	input  logic                 miss_evt_i,
	output logic                 flush_o
);

	localparam int N_SETS = N_LINES / N_WAYS;
	localparam cache_pkg::reg_data_t GEOMETRY = {8'(N_SETS), 8'(N_WAYS)};

	cache_pkg::count_t    hits_q;
	cache_pkg::count_t    misses_q;
	cache_pkg::reg_data_t rd_mux;
	logic                 flush_wr;

	// flush on a control write with bit 0 set
	assign flush_wr = reg_wr_i && (reg_addr_i == cache_pkg::REG_CTRL) && reg_wdata_i[0];

	// ---------------------------------------------------------
	// counters and flush strobe
	// ---------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			hits_q   <= '0;
			misses_q <= '0;
			flush_o  <= 1'b0;
		end else begin
			flush_o <= flush_wr;	// one cycle
			if (flush_wr) begin
				hits_q   <= '0;
				misses_q <= '0;
			end else begin
				if (hit_evt_i) hits_q <= hits_q + 1'b1;			// wraps
				if (miss_evt_i) misses_q <= misses_q + 1'b1;
			end
		end
	end

	// ---------------------------------------------------------
	// readback
	// ---------------------------------------------------------
	always_comb begin
		case (reg_addr_i)
			cache_pkg::REG_CTRL:     rd_mux = '0;	// command only
			cache_pkg::REG_HITS:     rd_mux = cache_pkg::reg_data_t'(hits_q);
			cache_pkg::REG_MISSES:   rd_mux = cache_pkg::reg_data_t'(misses_q);
			cache_pkg::REG_GEOMETRY: rd_mux = GEOMETRY;
			default:                 rd_mux = '0;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			reg_rvalid_o <= 1'b0;
		end else begin
			reg_rvalid_o <= reg_rd_i;	// data one cycle after the strobe
		end
	end

	always_ff @(posedge clock_i) begin
		if (reg_rd_i) reg_rdata_o <= rd_mux;
	end

	// software flushes only while the directory is idle
	a_flush_when_quiet: assert property (@(posedge clock_i) disable iff (!resetn_i)
		flush_o |-> !(hit_evt_i || miss_evt_i));

endmodule

// File: logic/cache_dir_top.sv
`timescale 1ns/10ps
// cache tag directory top level
// directory, fifo replacement and control registers with plain ports

module cache_dir_top #(
	parameter int N_LINES = cache_pkg::DEF_LINES,
	parameter int N_WAYS  = cache_pkg::DEF_WAYS
)(
	input  logic                       clock_i,
	input  logic                       resetn_i,
	// lookup port
	input  logic                       lookup_i,
	input  cache_pkg::addr_t           lookup_addr_i,
	output logic                       resp_valid_o,
	output logic                       resp_hit_o,
	output logic [$clog2(N_LINES)-1:0] resp_line_o,	// way above set
	output logic                       busy_o,
	// register port
	input  logic                       reg_wr_i,
	input  logic                       reg_rd_i,
	input  cache_pkg::reg_addr_t       reg_addr_i,
	input  cache_pkg::reg_data_t       reg_wdata_i,
	output logic                       reg_rvalid_o,
	output cache_pkg::reg_data_t       reg_rdata_o
);

	logic flush;	// registers to directory
	logic hit_evt;
	logic miss_evt;

	replace_if #(.N_LINES(N_LINES), .N_WAYS(N_WAYS)) rpl_if ();

	tag_directory #(.N_LINES(N_LINES), .N_WAYS(N_WAYS)) u_dir (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.lookup_i      (lookup_i),
		.lookup_addr_i (lookup_addr_i),
		.resp_valid_o  (resp_valid_o),
		.resp_hit_o    (resp_hit_o),
		.resp_line_o   (resp_line_o),
		.busy_o        (busy_o),
		.flush_i       (flush),
		.hit_evt_o     (hit_evt),
		.miss_evt_o    (miss_evt),
		.rpl           (rpl_if.requester)
	);

	fifo_replacement #(.N_LINES(N_LINES), .N_WAYS(N_WAYS)) u_rpl (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.rpl      (rpl_if.controller)
	);

	cache_ctrl_regs #(.N_LINES(N_LINES), .N_WAYS(N_WAYS)) u_regs (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.reg_wr_i     (reg_wr_i),
		.reg_rd_i     (reg_rd_i),
		.reg_addr_i   (reg_addr_i),
		.reg_wdata_i  (reg_wdata_i),
		.reg_rvalid_o (reg_rvalid_o),
		.reg_rdata_o  (reg_rdata_o),
		.hit_evt_i    (hit_evt),
		.miss_evt_i   (miss_evt),
		.flush_o      (flush)
	);

endmodule

// File: verif/cache_dir_checker.sv
`timescale 1ns/10ps
// cache directory checker
// compares lookup and register responses with expected values, counts errors

module cache_dir_checker #(
	parameter int LINE_W = 4
)(
	input  logic                 clock_i,
	input  logic                 resetn_i,
	// dut ports
	input  logic                 lookup_i,
	input  logic                 busy_i,
	input  logic                 resp_valid_i,
	input  logic                 resp_hit_i,
	input  logic [LINE_W-1:0]    resp_line_i,
	input  logic                 reg_rvalid_i,
	input  cache_pkg::reg_data_t reg_rdata_i,
	// expectations from the testbench
	input  logic                 exp_lookup_i,	// a lookup response is due
	input  logic                 exp_hit_i,
	input  logic [LINE_W-1:0]    exp_line_i,
	input  logic                 exp_read_i,	// a register response is due
	input  cache_pkg::reg_data_t exp_rdata_i,
	input  logic                 fault_i,		// timeout seen by the driver
	input  logic                 report_i,
	output int                   errors_o
);

	int   checks     = 0;
	int   value_errs = 0;
	int   other_errs = 0;
	logic busy_exp;

	assign errors_o = value_errs + other_errs;

	// ---------------------------------------------------------
	// lookup responses
	// ---------------------------------------------------------
	always @(posedge clock_i) begin
		if (resetn_i && resp_valid_i) begin
			if (!exp_lookup_i) begin
				$display("unexpected lookup response at %0t", $time);
				other_errs++;
			end else begin
				checks++;
				if (resp_hit_i !== exp_hit_i) begin
					$display("Error: resp_hit_o = %h, expected %h", resp_hit_i, exp_hit_i);
					value_errs++;
				end
				if (resp_line_i !== exp_line_i) begin
					$display("Error: resp_line_o = %h, expected %h", resp_line_i, exp_line_i);
					value_errs++;
				end
			end
		end
	end

	// ---------------------------------------------------------
	// busy flag, high from accept through the response cycle
	// ---------------------------------------------------------
	always @(posedge clock_i) begin
		if (!resetn_i) begin
			busy_exp <= 1'b0;
		end else begin
			if (busy_i !== busy_exp) begin
				$display("Error: busy_o = %h, expected %h", busy_i, busy_exp);
				value_errs++;
			end
			if (lookup_i && !busy_exp) begin
				busy_exp <= 1'b1;	// accepted, later strobes ignored
			end else if (resp_valid_i) begin
				busy_exp <= 1'b0;
			end
		end
	end

	// ---------------------------------------------------------
	// register responses
	// ---------------------------------------------------------
	always @(posedge clock_i) begin
		if (resetn_i && reg_rvalid_i) begin
			if (!exp_read_i) begin
				$display("unexpected register read response at %0t", $time);
				other_errs++;
			end else begin
				checks++;
				if (reg_rdata_i !== exp_rdata_i) begin
					$display("Error: reg_rdata_o = %h, expected %h", reg_rdata_i, exp_rdata_i);
					value_errs++;
				end
			end
		end
	end

	// faults and the closing line
	always @(posedge clock_i) begin
		if (fault_i) other_errs++;	// timeout or bad operation in the driver
		if (report_i) begin
			$display("checker summary: %0d checks, %0d value errors, %0d other errors",
				checks, value_errs, other_errs);
		end
	end

endmodule

// File: verif/cache_dir_tb.sv
`timescale 1ns/10ps
// cache directory testbench
// clock, reset and operations from the tests file, compared in cache_dir_checker

module cache_dir_tb;

	localparam int N_LINES = cache_pkg::DEF_LINES;
	localparam int N_WAYS  = cache_pkg::DEF_WAYS;
	localparam int LINE_W  = $clog2(N_LINES);
	localparam int MAX_OPS = 64;
	localparam int TIMEOUT = 20;	// cycles per wait

	logic                 clock;
	logic                 resetn;
	logic                 lookup, resp_valid, resp_hit, busy;
	cache_pkg::addr_t     lookup_addr;
	logic [LINE_W-1:0]    resp_line;
	logic                 reg_wr, reg_rd, reg_rvalid;
	cache_pkg::reg_addr_t reg_addr;
	cache_pkg::reg_data_t reg_wdata, reg_rdata;
	logic                 exp_lookup, exp_hit, exp_read, fault, report;
	logic [LINE_W-1:0]    exp_line;
	cache_pkg::reg_data_t exp_rdata;
	int                   errors;
	logic [47:0]          ops [MAX_OPS];	// op_addr_hit_line_data

	initial clock = 1'b0;
	always #50 clock = ~clock;	// 100 ns period

	cache_dir_top #(.N_LINES(N_LINES), .N_WAYS(N_WAYS)) dut0 (
		.clock_i(clock), .resetn_i(resetn),
		.lookup_i(lookup), .lookup_addr_i(lookup_addr),
		.resp_valid_o(resp_valid), .resp_hit_o(resp_hit), .resp_line_o(resp_line),
		.busy_o(busy),
		.reg_wr_i(reg_wr), .reg_rd_i(reg_rd), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata),
		.reg_rvalid_o(reg_rvalid), .reg_rdata_o(reg_rdata)
	);

	cache_dir_checker #(.LINE_W(LINE_W)) chk0 (
		.clock_i(clock), .resetn_i(resetn),
		.lookup_i(lookup), .busy_i(busy),
		.resp_valid_i(resp_valid), .resp_hit_i(resp_hit), .resp_line_i(resp_line),
		.reg_rvalid_i(reg_rvalid), .reg_rdata_i(reg_rdata),
		.exp_lookup_i(exp_lookup), .exp_hit_i(exp_hit), .exp_line_i(exp_line),
		.exp_read_i(exp_read), .exp_rdata_i(exp_rdata),
		.fault_i(fault), .report_i(report), .errors_o(errors)
	);

	// ---------------------------------------------------------
	// waits, each bounded by TIMEOUT
	// ---------------------------------------------------------
	task automatic wait_idle(input int num, output bit aborted);
		int cnt;
		cnt     = 0;
		aborted = 1'b0;
		while (busy && cnt < TIMEOUT) begin
			@(posedge clock);
			cnt++;
		end
		if (busy) begin
			$display("timeout, directory still busy before operation %0d", num);
			fault   <= 1'b1;
			aborted = 1'b1;
		end
	endtask

	task automatic wait_response(input bit is_read, input int num, output bit aborted);
		int cnt;
		bit seen;
		cnt     = 0;
		seen    = 1'b0;
		aborted = 1'b0;
		while (!seen && cnt < TIMEOUT) begin
			@(posedge clock);
			lookup <= 1'b0;	// extra strobe lasts one busy cycle
			seen = is_read ? reg_rvalid : resp_valid;
			cnt++;
		end
		exp_lookup <= 1'b0;	// checker sampled them at this edge
		exp_read   <= 1'b0;
		if (!seen) begin
			$display("timeout, no response to operation %0d", num);
			fault   <= 1'b1;
			aborted = 1'b1;
		end
	endtask

	// ---------------------------------------------------------
	// operations
	// ---------------------------------------------------------
	task automatic run_lookup(input logic [47:0] op, input int num, output bit aborted);
		wait_idle(num, aborted);
		if (!aborted) begin
			@(posedge clock);
			lookup      <= 1'b1;
			lookup_addr <= op[43:28];
			exp_lookup  <= 1'b1;
			exp_hit     <= op[24];
			exp_line    <= op[16 +: LINE_W];
			@(posedge clock);
			lookup_addr <= ~op[43:28];	// second request while busy, must be dropped
			wait_response(1'b0, num, aborted);
		end
	endtask

	task automatic run_read(input logic [47:0] op, input int num, output bit aborted);
		@(posedge clock);
		reg_rd    <= 1'b1;
		reg_addr  <= op[29:28];
		exp_read  <= 1'b1;
		exp_rdata <= op[15:0];
		@(posedge clock);
		reg_rd <= 1'b0;
		wait_response(1'b1, num, aborted);
	endtask

	task automatic run_write(input logic [47:0] op);
		@(posedge clock);
		reg_wr    <= 1'b1;
		reg_addr  <= op[29:28];
		reg_wdata <= op[15:0];
		@(posedge clock);
		reg_wr <= 1'b0;
		repeat (2) @(posedge clock);	// flush strobe reaches the directory
	endtask

	task automatic finish_run();
		@(posedge clock);
		fault  <= 1'b0;
		report <= 1'b1;
		@(posedge clock);	// checker prints its summary here
		@(negedge clock);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	initial begin
		int idx;
		bit aborted;
		resetn      = 1'b0;
		lookup      = 1'b0;
		lookup_addr = '0;
		reg_wr      = 1'b0;
		reg_rd      = 1'b0;
		reg_addr    = '0;
		reg_wdata   = '0;
		exp_lookup  = 1'b0;
		exp_hit     = 1'b0;
		exp_line    = '0;
		exp_read    = 1'b0;
		exp_rdata   = '0;
		fault       = 1'b0;
		report      = 1'b0;
		for (idx = 0; idx < MAX_OPS; idx++) begin
			ops[idx] = '0;	// op 0 ends the list
		end
		$readmemh("verif/cache_dir_tests.txt", ops);
		repeat (16) @(posedge clock);
		resetn <= 1'b1;
		@(posedge clock);
		aborted = 1'b0;
		idx     = 0;
		while (idx < MAX_OPS && ops[idx][47:44] != 4'h0 && !aborted) begin
			case (ops[idx][47:44])
				4'h1: run_lookup(ops[idx], idx, aborted);
				4'h2: run_read(ops[idx], idx, aborted);
				4'h3: run_write(ops[idx]);
				default: begin
					$display("unknown operation code in line %0d of the tests file", idx);
					fault   <= 1'b1;
					aborted = 1'b1;
				end
			endcase
			idx++;
		end
		if (idx == 0) begin
			$display("no operations found in the tests file");
			fault <= 1'b1;
		end
		finish_run();
	end

endmodule

// File: cache_dir_top.f
logic/cache_pkg.sv
logic/replace_if.sv
logic/fifo_replacement.sv
logic/tag_directory.sv
logic/cache_ctrl_regs.sv
logic/cache_dir_top.sv
verif/cache_dir_checker.sv
verif/cache_dir_tb.sv

// File: Bender.yml
package:
  name: cache_dir

sources:
  - logic/cache_pkg.sv
  - logic/replace_if.sv
  - logic/fifo_replacement.sv
  - logic/tag_directory.sv
  - logic/cache_ctrl_regs.sv
  - logic/cache_dir_top.sv
  - target: test
    files:
      - verif/cache_dir_checker.sv
      - verif/cache_dir_tb.sv

// File: verif/cache_dir_tests.txt
// fields op_addr_hit_line_data, op 1 lookup, 2 register read, 3 register write
// addr is a block address or a register select, hit/line/data are expected values or write data
// cold miss, then a hit on the same line
1_0010_0_00_0000
1_0010_1_00_0000
// five tags into set 0, the fifth wraps to way 0
1_0020_0_04_0000
1_0030_0_08_0000
1_0040_0_0c_0000
1_0050_0_00_0000
// evicted tag misses again, fifth tag still there
1_0010_0_04_0000
1_0050_1_00_0000
// independent pointers per set
1_0101_0_01_0000
1_0201_0_05_0000
1_0102_0_02_0000
1_0203_0_03_0000
1_0201_1_05_0000
// counters, geometry and control readback
2_0001_0_00_0003
2_0002_0_00_000a
2_0003_0_00_0404
2_0000_0_00_0000
// flush, counters back to zero
3_0000_0_00_0001
2_0001_0_00_0000
2_0002_0_00_0000
// everything misses again, pointers restart at way 0
1_0050_0_00_0000
1_0101_0_01_0000
1_0030_0_04_0000
1_0050_1_00_0000
2_0001_0_00_0001
2_0002_0_00_0003
